/* Bender.yml */
package:
  name: dual_logger

sources:
  - src/logger_pkg.sv
  - src/sample_fifo.sv
  - src/ring_writer.sv
  - src/wb_rr_arbiter.sv
  - src/dual_logger_top.sv
  - target: test
    files:
      - bench/dual_logger_checker.sv
      - bench/dual_logger_tb.sv

/* bench/dual_logger_checker.sv */
// ====================
// dual_logger_checker
// wishbone classic protocol assertions for the logger bus
// ====================
`timescale 1ns/1ps
`default_nettype none

module dual_logger_checker (
  input logic                               clk_i,
  input logic                               rst_i,
  input logic                               cyc_i,
  input logic                               stb_i,
  input logic                               we_i,
  input logic [logger_pkg::WB_ADDR_W-1:0]   adr_i,
  input logic [logger_pkg::WB_DATA_W-1:0]   dat_i,
  input logic [logger_pkg::WB_DATA_W/8-1:0] sel_i,
  input logic                               ack_i,
  input logic                               m0_cyc_i,
  input logic                               m0_ack_i,
  input logic                               m1_cyc_i,
  input logic                               m1_ack_i
);

  int fail_cnt = 0;

  a_stb_cyc: assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> cyc_i)
    else begin fail_cnt++; $error("stb high without cyc"); end

  // request held steady until the slave acks
  a_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (stb_i && !ack_i) |=> ($stable(adr_i) && $stable(dat_i) && $stable(sel_i)))
    else begin fail_cnt++; $error("adr, dat or sel moved before ack"); end

  a_we: assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> we_i)
    else begin fail_cnt++; $error("read cycle on a write-only bus"); end

  // per writer, since the merged cyc can stay high across owners
  a_m0_drop: assert property (@(posedge clk_i) disable iff (rst_i)
    (m0_cyc_i && m0_ack_i) |=> !m0_cyc_i)
    else begin fail_cnt++; $error("channel 0 kept cyc after its ack"); end

  a_m1_drop: assert property (@(posedge clk_i) disable iff (rst_i)
    (m1_cyc_i && m1_ack_i) |=> !m1_cyc_i)
    else begin fail_cnt++; $error("channel 1 kept cyc after its ack"); end

endmodule

`default_nettype wire

/* bench/dual_logger_patterns.txt */
# push <channel> <hex value>, stall <1 hold ack | 0 release and drain>
# expect_full <channel> <flag>
push 0 11
push 0 22
push 1 a001
push 0 33
push 1 a002
push 1 a003
push 0 44
push 0 55
stall 0
# ten pushes into a stalled channel 0, eight fit
stall 1
push 0 60
push 0 61
push 0 62
push 0 63
push 0 64
push 0 65
push 0 66
push 0 67
push 0 68
push 0 69
expect_full 0 1
expect_full 1 0
stall 0
expect_full 0 0
# both channels pending, writes alternate on release
stall 1
push 0 70
push 1 b001
push 0 71
push 1 b002
push 0 72
push 1 b003
push 0 73
stall 0
push 1 c0de

/* bench/dual_logger_tb.sv */
// ====================
// dual_logger_tb
// pattern-driven testbench with a wishbone slave memory model
// ====================
`timescale 1ns/1ps
`default_nettype none

module dual_logger_tb;

  localparam int RING  = 2**logger_pkg::RING_BITS;
  localparam int DEPTH = 2**logger_pkg::FIFO_ADDR_BITS;

  logic        clk, rst;
  logic        ch0_push, ch0_full, ch1_push, ch1_full;
  logic [7:0]  ch0_data;
  logic [15:0] ch1_data;
  logic        wb_cyc, wb_stb, wb_we, wb_ack;
  logic        cap_we;
  logic [15:0] wb_adr, cap_adr;
  logic [31:0] wb_dat, cap_dat;
  logic [3:0]  wb_sel, cap_sel;
  int          errors, checks, cycles, limit, wait_left, last_ch;
  int          fill [2];     // accepted but not yet written, per channel
  int          wr_idx [2];   // completed writes per channel
  integer      seed;
  logic        stall_on, armed, other_waiting;
  logic [31:0] exp0_q [$];
  logic [31:0] exp1_q [$];
  logic [31:0] mem [logic [15:0]];
  int          rec_kind [$];  // 0 push, 1 stall, 2 expect_full
  int          rec_ch [$];
  logic [15:0] rec_val [$];

  dual_logger_top DUT (
    .clk_i(clk), .rst_i(rst), .ch0_push_i(ch0_push), .ch0_data_i(ch0_data),
    .ch0_full_o(ch0_full), .ch1_push_i(ch1_push), .ch1_data_i(ch1_data),
    .ch1_full_o(ch1_full), .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we),
    .wb_adr_o(wb_adr), .wb_dat_o(wb_dat), .wb_sel_o(wb_sel), .wb_ack_i(wb_ack)
  );

  bind dual_logger_top dual_logger_checker u_checker (
    .clk_i(clk_i), .rst_i(rst_i), .cyc_i(wb_cyc_o), .stb_i(wb_stb_o), .we_i(wb_we_o),
    .adr_i(wb_adr_o), .dat_i(wb_dat_o), .sel_i(wb_sel_o), .ack_i(wb_ack_i),
    .m0_cyc_i(m0_cyc), .m0_ack_i(m0_ack), .m1_cyc_i(m1_cyc), .m1_ack_i(m1_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: the run stalled, still busy after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic check_eq(input logic [31:0] got, input logic [31:0] want, input string msg);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Fail at %0t: %s, got %0h, expected %0h", $time, msg, got, want);
    end
  endtask

  // one finished transfer, checked against the push order of its channel
  task automatic commit_write();
    int          c;
    logic [31:0] want;
    logic [15:0] base;
    if (cap_adr >= logger_pkg::CH1_BASE && cap_adr < logger_pkg::CH1_BASE + RING) begin
      c = 1;
    end else if (cap_adr >= logger_pkg::CH0_BASE && cap_adr < logger_pkg::CH0_BASE + RING) begin
      c = 0;
    end else begin
      errors++;
      $display("write to address %h lies outside both rings", cap_adr);
      return;
    end
    if ((c == 0 && exp0_q.size() == 0) || (c == 1 && exp1_q.size() == 0)) begin
      errors++;
      $display("channel %0d wrote an item that was never accepted", c);
      return;
    end
    if (c == 0) begin
      want = exp0_q.pop_front();
      base = logger_pkg::CH0_BASE;
    end else begin
      want = exp1_q.pop_front();
      base = logger_pkg::CH1_BASE;
    end
    check_eq(cap_adr, base + wr_idx[c] % RING, "ring address");   // wraps every 16
    check_eq(cap_dat, want, "data word");
    check_eq(cap_sel, 4'hf, "byte selects");
    check_eq(cap_we, 1'b1, "write enable");
    if (other_waiting) begin
      check_eq(c, 1 - last_ch, "round-robin owner");
    end
    mem[cap_adr] = cap_dat;
    wr_idx[c]++;
    fill[c]--;
    last_ch = c;
    other_waiting = (fill[1 - c] > 0);
  endtask

  task automatic serve_slave();
    if (wb_ack) begin
      wb_ack = 1'b0;  // transfer closed at the last rising edge
      commit_write();
    end else if (wb_stb && !stall_on) begin
      if (!armed) begin
        wait_left = {$random(seed)} % 4;
        armed = 1'b1;
      end
      if (wait_left == 0) begin
        cap_adr = wb_adr;
        cap_dat = wb_dat;
        cap_sel = wb_sel;
        cap_we = wb_we;
        armed = 1'b0;
        wb_ack = 1'b1;
      end else begin
        wait_left--;
      end
    end
  endtask

  task automatic tick();
    @(negedge clk);
    ch0_push = 1'b0;
    ch1_push = 1'b0;
    serve_slave();
  endtask

  task automatic push_item(input int ch, input logic [15:0] val);
    tick();
    if (ch == 0) begin
      ch0_push = 1'b1;
      ch0_data = val[7:0];
    end else begin
      ch1_push = 1'b1;
      ch1_data = val;
    end
    if (fill[ch] < DEPTH) begin  // a full fifo drops the push
      fill[ch]++;
      if (ch == 0) begin
        exp0_q.push_back({24'h0, val[7:0]});
      end else begin
        exp1_q.push_back({16'h0, val});
      end
    end
  endtask

  task automatic drain();
    stall_on = 1'b0;
    while (fill[0] != 0 || fill[1] != 0) begin
      tick();
    end
  endtask

  function automatic bit load_patterns();
    int          fd;
    int          ch;
    logic [15:0] val;
    string       tok;
    string       rest;
    fd = $fopen("bench/dual_logger_patterns.txt", "r");
    if (fd == 0) begin
      return 1'b0;
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok.getc(0) == "#") begin
        void'($fgets(rest, fd));
      end else if (tok == "push" || tok == "expect_full") begin
        void'($fscanf(fd, "%d %h", ch, val));
        rec_kind.push_back(tok == "push" ? 0 : 2);
        rec_ch.push_back(ch);
        rec_val.push_back(val);
      end else begin
        void'($fscanf(fd, "%d", ch));  // stall 1 holds ack, stall 0 releases
        rec_kind.push_back(1);
        rec_ch.push_back(ch);
        rec_val.push_back('0);
      end
    end
    $fclose(fd);
    return 1'b1;
  endfunction

  task automatic run_all();
    int i;
    limit = 40 * rec_kind.size() + 200;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (i = 0; i < 4; i++) begin  // idle bus until the first push
      tick();
      check_eq(wb_cyc, 1'b0, "cyc with no push");
      check_eq(wb_stb, 1'b0, "stb with no push");
      check_eq({ch1_full, ch0_full}, 2'b00, "full flags after reset");
    end
    for (i = 0; i < rec_kind.size(); i++) begin
      if (rec_kind[i] == 0) begin
        push_item(rec_ch[i], rec_val[i]);
      end else if (rec_kind[i] == 1 && rec_ch[i] != 0) begin
        stall_on = 1'b1;
      end else if (rec_kind[i] == 1) begin
        drain();
      end else begin
        tick();
        check_eq(rec_ch[i] == 0 ? ch0_full : ch1_full, rec_val[i], "full flag");
      end
    end
    drain();
    repeat (3) tick();
    check_eq(wb_cyc, 1'b0, "cyc after drain");
    check_eq(mem.num(), (wr_idx[0] < RING ? wr_idx[0] : RING)
                      + (wr_idx[1] < RING ? wr_idx[1] : RING), "words in memory");
    check_eq(DUT.u_checker.fail_cnt, 0, "protocol assertion failures");
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  initial begin
    rst = 1'b1;
    ch0_push = 1'b0;
    ch0_data = '0;
    ch1_push = 1'b0;
    ch1_data = '0;
    wb_ack = 1'b0;
    {errors, checks, cycles, limit, wait_left, last_ch} = '0;
    fill = '{0, 0};
    wr_idx = '{0, 0};
    seed = 32'h57a3;
    {stall_on, armed, other_waiting} = '0;
    if (!load_patterns()) begin
      $display("pattern file bench/dual_logger_patterns.txt could not be opened");
      $display("ERRORS FOUND");
      $finish;
    end else begin
      run_all();
    end
  end

endmodule

`default_nettype wire

/* dual_logger_top.f */
src/logger_pkg.sv
src/sample_fifo.sv
src/ring_writer.sv
src/wb_rr_arbiter.sv
src/dual_logger_top.sv
bench/dual_logger_checker.sv
bench/dual_logger_tb.sv

/* src/dual_logger_top.sv */
// ====================
// dual_logger_top
// byte and sample channels, each fifo plus ring writer, merged on one bus
// ====================
`timescale 1ns/1ps
`default_nettype none

module dual_logger_top (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               ch0_push_i,
  input  logger_pkg::byte_item_t             ch0_data_i,
  output logic                               ch0_full_o,
  input  logic                               ch1_push_i,
  input  logger_pkg::sample_item_t           ch1_data_i,
  output logic                               ch1_full_o,
  output logic                               wb_cyc_o,
  output logic                               wb_stb_o,
  output logic                               wb_we_o,
  output logic [logger_pkg::WB_ADDR_W-1:0]   wb_adr_o,
  output logic [logger_pkg::WB_DATA_W-1:0]   wb_dat_o,
  output logic [logger_pkg::WB_DATA_W/8-1:0] wb_sel_o,
  input  logic                               wb_ack_i
);

  // fifo to writer
  logic                     ch0_empty, ch0_pop;
  logic                     ch1_empty, ch1_pop;
  logger_pkg::byte_item_t   ch0_head;
  logger_pkg::sample_item_t ch1_head;

  // writers to arbiter
  logic                               m0_cyc, m0_stb, m0_we, m0_ack;
  logic                               m1_cyc, m1_stb, m1_we, m1_ack;
  logic [logger_pkg::WB_ADDR_W-1:0]   m0_adr, m1_adr;
  logic [logger_pkg::WB_DATA_W-1:0]   m0_dat, m1_dat;
  logic [logger_pkg::WB_DATA_W/8-1:0] m0_sel, m1_sel;

  sample_fifo #(.payload_t(logger_pkg::byte_item_t)) u_ch0_fifo (
    .clk_i, .rst_i, .push_i(ch0_push_i), .pop_i(ch0_pop), .push_data_i(ch0_data_i),
    .head_o(ch0_head), .empty_o(ch0_empty), .full_o(ch0_full_o)
  );

  sample_fifo #(.payload_t(logger_pkg::sample_item_t)) u_ch1_fifo (
    .clk_i, .rst_i, .push_i(ch1_push_i), .pop_i(ch1_pop), .push_data_i(ch1_data_i),
    .head_o(ch1_head), .empty_o(ch1_empty), .full_o(ch1_full_o)
  );

  ring_writer #(
    .payload_t(logger_pkg::byte_item_t),
    .BASE_ADDR(logger_pkg::CH0_BASE)
  ) u_ch0_writer (
    .clk_i, .rst_i, .empty_i(ch0_empty), .head_i(ch0_head), .pop_o(ch0_pop),
    .wb_cyc_o(m0_cyc), .wb_stb_o(m0_stb), .wb_we_o(m0_we), .wb_adr_o(m0_adr),
    .wb_dat_o(m0_dat), .wb_sel_o(m0_sel), .wb_ack_i(m0_ack)
  );

  ring_writer #(
    .payload_t(logger_pkg::sample_item_t),
    .BASE_ADDR(logger_pkg::CH1_BASE)
  ) u_ch1_writer (
    .clk_i, .rst_i, .empty_i(ch1_empty), .head_i(ch1_head), .pop_o(ch1_pop),
    .wb_cyc_o(m1_cyc), .wb_stb_o(m1_stb), .wb_we_o(m1_we), .wb_adr_o(m1_adr),
    .wb_dat_o(m1_dat), .wb_sel_o(m1_sel), .wb_ack_i(m1_ack)
  );

  wb_rr_arbiter u_arbiter (
    .clk_i, .rst_i,
    .m0_cyc_i(m0_cyc), .m0_stb_i(m0_stb), .m0_we_i(m0_we), .m0_adr_i(m0_adr),
    .m0_dat_i(m0_dat), .m0_sel_i(m0_sel), .m0_ack_o(m0_ack),
    .m1_cyc_i(m1_cyc), .m1_stb_i(m1_stb), .m1_we_i(m1_we), .m1_adr_i(m1_adr),
    .m1_dat_i(m1_dat), .m1_sel_i(m1_sel), .m1_ack_o(m1_ack),
    .s_cyc_o(wb_cyc_o), .s_stb_o(wb_stb_o), .s_we_o(wb_we_o), .s_adr_o(wb_adr_o),
    .s_dat_o(wb_dat_o), .s_sel_o(wb_sel_o), .s_ack_i(wb_ack_i)
  );

endmodule

`default_nettype wire

/* src/logger_pkg.sv */
// ====================
// logger_pkg
// shared widths, ring bases and payload types for the dual sample logger
// ====================
`default_nettype none

package logger_pkg;

  // fifo depth is 2**FIFO_ADDR_BITS
  localparam int FIFO_ADDR_BITS = 3;

  // wishbone word address and data widths
  localparam int WB_ADDR_W = 16;
  localparam int WB_DATA_W = 32;

  // words per ring region is 2**RING_BITS
  localparam int RING_BITS = 4;

  localparam logic [WB_ADDR_W-1:0] CH0_BASE = 16'h0100;  // byte channel ring
  localparam logic [WB_ADDR_W-1:0] CH1_BASE = 16'h0200;  // sample channel ring

  typedef logic [7:0]  byte_item_t;    // channel 0 payload
  typedef logic [15:0] sample_item_t;  // channel 1 payload

endpackage

`default_nettype wire

/* src/ring_writer.sv */
// ====================
// ring_writer
// drains one fifo into a wrapping ring of words with wishbone writes
// ====================
`timescale 1ns/1ps
`default_nettype none

module ring_writer #(
  parameter type                                payload_t = logic [7:0],
  parameter logic [logger_pkg::WB_ADDR_W-1:0] BASE_ADDR = '0
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               empty_i,
  input  payload_t                           head_i,
  output logic                               pop_o,
  output logic                               wb_cyc_o,
  output logic                               wb_stb_o,
  output logic                               wb_we_o,
  output logic [logger_pkg::WB_ADDR_W-1:0]   wb_adr_o,
  output logic [logger_pkg::WB_DATA_W-1:0]   wb_dat_o,
  output logic [logger_pkg::WB_DATA_W/8-1:0] wb_sel_o,
  input  logic                               wb_ack_i
);

  typedef enum logic {
    st_idle,
    st_busy
  } state_t;

  state_t                            state_q;
  logic [logger_pkg::RING_BITS-1:0] ring_idx_q;    // wraps modulo ring size
  logic [logger_pkg::WB_ADDR_W-1:0] adr_q;
  logic [logger_pkg::WB_DATA_W-1:0] dat_q;
  logic                             launch;
  logic                             done;

  assign launch = (state_q == st_idle) & ~empty_i;
  assign done   = (state_q == st_busy) & wb_ack_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= st_idle;
      ring_idx_q <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          if (launch) begin
            state_q <= st_busy;
          end
        end
        st_busy: begin
          if (done) begin
            state_q    <= st_idle;
            ring_idx_q <= ring_idx_q + 1'b1;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // address and data captured once per item, held until ack
  always_ff @(posedge clk_i) begin
    if (launch) begin
      adr_q <= BASE_ADDR
             + {{(logger_pkg::WB_ADDR_W-logger_pkg::RING_BITS){1'b0}}, ring_idx_q};
      dat_q <= {{(logger_pkg::WB_DATA_W-$bits(payload_t)){1'b0}}, head_i};
    end
  end

  // item leaves the fifo only once the write is acked
  assign pop_o = done;

  assign wb_cyc_o = (state_q == st_busy);
  assign wb_stb_o = (state_q == st_busy);
  assign wb_we_o  = (state_q == st_busy);   // write-only master
  assign wb_adr_o = adr_q;
  assign wb_dat_o = dat_q;
  assign wb_sel_o = '1;                     // full word every time

endmodule

`default_nettype wire

/* src/sample_fifo.sv */
// ====================
// sample_fifo
// register-array fifo for any payload type, registered full and empty
// ====================
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  ADDR_BITS = logger_pkg::FIFO_ADDR_BITS
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     push_i,
  input  logic     pop_i,
  input  payload_t push_data_i,
  output payload_t head_o,
  output logic     empty_o,
  output logic     full_o
);

  payload_t             mem_reg [2**ADDR_BITS];
  logic [ADDR_BITS-1:0] w_ptr_reg, w_ptr_next, w_ptr_succ;
  logic [ADDR_BITS-1:0] r_ptr_reg, r_ptr_next, r_ptr_succ;
  logic                 full_reg, full_next;
  logic                 empty_reg, empty_next;
  logic                 wr_en;
  logic                 rd_en;

  assign wr_en = push_i & ~full_reg;   // full: push is dropped, pop still runs
  assign rd_en = pop_i & ~empty_reg;   // pop on empty does nothing

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_reg[w_ptr_reg] <= push_data_i;
    end
  end

  assign head_o = mem_reg[r_ptr_reg];  // no clock delay on the head

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      w_ptr_reg <= '0;
      r_ptr_reg <= '0;
      full_reg  <= 1'b0;
      empty_reg <= 1'b1;
    end else begin
      w_ptr_reg <= w_ptr_next;
      r_ptr_reg <= r_ptr_next;
      full_reg  <= full_next;
      empty_reg <= empty_next;
    end
  end

  always_comb begin
    w_ptr_succ = w_ptr_reg + 1'b1;
    r_ptr_succ = r_ptr_reg + 1'b1;
    w_ptr_next = w_ptr_reg;
    r_ptr_next = r_ptr_reg;
    full_next  = full_reg;
    empty_next = empty_reg;
    case ({wr_en, rd_en})
      2'b01: begin  // read only
        r_ptr_next = r_ptr_succ;
        full_next  = 1'b0;
        empty_next = (r_ptr_succ == w_ptr_reg);
      end
      2'b10: begin  // write only
        w_ptr_next = w_ptr_succ;
        empty_next = 1'b0;
        full_next  = (w_ptr_succ == r_ptr_reg);
      end
      2'b11: begin  // both, occupancy unchanged so flags hold
        w_ptr_next = w_ptr_succ;
        r_ptr_next = r_ptr_succ;
      end
      default: ;
    endcase
  end

  assign full_o  = full_reg;
  assign empty_o = empty_reg;

endmodule

`default_nettype wire

/* src/wb_rr_arbiter.sv */
// ====================
// wb_rr_arbiter
// two wishbone classic masters onto one slave, round-robin grant
// ====================
`timescale 1ns/1ps
`default_nettype none

module wb_rr_arbiter (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               m0_cyc_i,
  input  logic                               m0_stb_i,
  input  logic                               m0_we_i,
  input  logic [logger_pkg::WB_ADDR_W-1:0]   m0_adr_i,
  input  logic [logger_pkg::WB_DATA_W-1:0]   m0_dat_i,
  input  logic [logger_pkg::WB_DATA_W/8-1:0] m0_sel_i,
  output logic                               m0_ack_o,
  input  logic                               m1_cyc_i,
  input  logic                               m1_stb_i,
  input  logic                               m1_we_i,
  input  logic [logger_pkg::WB_ADDR_W-1:0]   m1_adr_i,
  input  logic [logger_pkg::WB_DATA_W-1:0]   m1_dat_i,
  input  logic [logger_pkg::WB_DATA_W/8-1:0] m1_sel_i,
  output logic                               m1_ack_o,
  output logic                               s_cyc_o,
  output logic                               s_stb_o,
  output logic                               s_we_o,
  output logic [logger_pkg::WB_ADDR_W-1:0]   s_adr_o,
  output logic [logger_pkg::WB_DATA_W-1:0]   s_dat_o,
  output logic [logger_pkg::WB_DATA_W/8-1:0] s_sel_o,
  input  logic                               s_ack_i
);

  logic grant_q;    // owner while locked, 1 = m1
  logic locked_q;   // a cycle is running through the arbiter
  logic last_q;     // master served last
  logic pick;
  logic owner;
  logic done;

  // both asking: the one not served last wins
  always_comb begin
    if (m0_cyc_i && m1_cyc_i) begin
      pick = ~last_q;
    end else if (m1_cyc_i) begin
      pick = 1'b1;
    end else if (m0_cyc_i) begin
      pick = 1'b0;
    end else begin
      pick = grant_q;
    end
  end

  assign owner = locked_q ? grant_q : pick;
  assign done  = s_cyc_o & s_stb_o & s_ack_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      grant_q  <= 1'b0;
      locked_q <= 1'b0;
      last_q   <= 1'b0;
    end else if (done) begin
      locked_q <= 1'b0;      // owner drops cyc on this same edge
      last_q   <= owner;
    end else if (s_cyc_o && !locked_q) begin
      locked_q <= 1'b1;
      grant_q  <= owner;
    end
  end

  assign s_cyc_o = owner ? m1_cyc_i : m0_cyc_i;
  assign s_stb_o = owner ? m1_stb_i : m0_stb_i;
  assign s_we_o  = owner ? m1_we_i  : m0_we_i;
  assign s_adr_o = owner ? m1_adr_i : m0_adr_i;
  assign s_dat_o = owner ? m1_dat_i : m0_dat_i;
  assign s_sel_o = owner ? m1_sel_i : m0_sel_i;

  assign m0_ack_o = s_ack_i & ~owner;
  assign m1_ack_o = s_ack_i & owner;

endmodule

`default_nettype wire
